// ==== bench/tb_rdma_req_top.sv ====
/*
 * Testbench for the RDMA request splitter
 * A reference model expands each accepted command into its expected pieces,
 * and assertions compare every output handshake with the head of that list
 */

`timescale 1ns/1ps
`default_nettype none

`include "rdma_config.svh"

module tb_rdma_req_top
    import rdma_opcode_pkg::*;
    import rdma_req_pkg::*;
();

    localparam len_t PMTU       = len_t'(`RDMA_PMTU_BYTES);
    localparam len_t MAX_RD     = len_t'(`RDMA_MAX_SINGLE_READ);
    localparam int   WAIT_LIMIT = 2000; // Cycles per wait

    logic      aclk, aresetn;
    logic      in_valid, in_ready, out_valid, out_ready;
    rdma_req_t in_req, out_req;

    rdma_req_t exp_q[$];   // Expected pieces in output order
    rdma_req_t exp_head;
    int        exp_count;
    int        errors, checks, seed;
    logic      ready_rand; // Random back-pressure on the output
    logic      hs;
    string     test_name;

    rdma_req_top dut_i (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic void expand(rdma_req_t c);
        rdma_req_t p;
        len_t      rem, lim;
        int        kind;   // 0 read, 1 write, 2 send
        logic      fits, first;
        p = c;
        if (c.mode == MODE_RAW && c.opcode != RC_RDMA_READ_REQUEST) begin
            p.last = c.last && (c.opcode inside {RC_RDMA_WRITE_LAST, RC_RDMA_WRITE_ONLY,
                                                 RC_SEND_LAST, RC_SEND_ONLY});
            exp_q.push_back(p);
            return;
        end
        if (c.mode == MODE_RAW || c.opcode == APP_READ) kind = 0;
        else if (c.opcode == APP_WRITE) kind = 1;
        else if (c.opcode == APP_SEND) kind = 2;
        else return; // Unknown application opcode, nothing expected
        lim   = (kind == 0) ? MAX_RD : PMTU;
        rem   = c.len;
        first = 1'b1;
        do begin
            fits     = (rem <= lim);
            p.len    = fits ? rem : lim;
            p.last   = fits && c.last; // Only the final piece
            p.lvaddr = c.lvaddr;
            p.rvaddr = (kind == 2) ? '0 : c.rvaddr;
            case (kind)
                0: p.opcode = RC_RDMA_READ_REQUEST;
                1: p.opcode = first ? (fits ? RC_RDMA_WRITE_ONLY : RC_RDMA_WRITE_FIRST)
                                    : (fits ? RC_RDMA_WRITE_LAST : RC_RDMA_WRITE_MIDDLE);
                default: p.opcode = first ? (fits ? RC_SEND_ONLY : RC_SEND_FIRST)
                                          : (fits ? RC_SEND_LAST : RC_SEND_MIDDLE);
            endcase
            exp_q.push_back(p);
            c.lvaddr = c.lvaddr + vaddr_t'(lim);
            c.rvaddr = c.rvaddr + vaddr_t'(lim);
            rem      = rem - p.len;
            first    = 1'b0;
        end while (rem != '0);
    endfunction

    always @(posedge aclk) begin
        if (aresetn) begin
            if (out_valid && out_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                checks++;
            end
            if (in_valid && in_ready) begin
                expand(in_req);
            end
        end
        exp_count = exp_q.size();
        exp_head  = (exp_count != 0) ? exp_q[0] : '0;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic report_diff(string field, logic [63:0] exp, logic [63:0] act);
        errors++;
        $display("[FAIL] %s %s expected %h actual %h", test_name, field, exp, act);
    endtask

    assign hs = out_valid && out_ready && (exp_count != 0);

    a_opcode: assert property (@(posedge aclk) disable iff (!aresetn)
        hs |-> out_req.opcode == exp_head.opcode)
        else report_diff("opcode", $sampled(exp_head.opcode), $sampled(out_req.opcode));
    a_last: assert property (@(posedge aclk) disable iff (!aresetn)
        hs |-> out_req.last == exp_head.last)
        else report_diff("last", $sampled(exp_head.last), $sampled(out_req.last));
    a_len: assert property (@(posedge aclk) disable iff (!aresetn)
        hs |-> out_req.len == exp_head.len)
        else report_diff("len", $sampled(exp_head.len), $sampled(out_req.len));
    a_lvaddr: assert property (@(posedge aclk) disable iff (!aresetn)
        hs |-> out_req.lvaddr == exp_head.lvaddr)
        else report_diff("lvaddr", $sampled(exp_head.lvaddr), $sampled(out_req.lvaddr));
    a_rvaddr: assert property (@(posedge aclk) disable iff (!aresetn)
        hs |-> out_req.rvaddr == exp_head.rvaddr)
        else report_diff("rvaddr", $sampled(exp_head.rvaddr), $sampled(out_req.rvaddr));
    // Mode, qpn, ssn and params together
    a_ids: assert property (@(posedge aclk) disable iff (!aresetn)
        hs |-> {out_req.mode, out_req.qpn, out_req.ssn, out_req.params} ==
               {exp_head.mode, exp_head.qpn, exp_head.ssn, exp_head.params})
        else report_diff("mode/qpn/ssn/params",
            $sampled({exp_head.mode, exp_head.qpn, exp_head.ssn, exp_head.params}),
            $sampled({out_req.mode, out_req.qpn, out_req.ssn, out_req.params}));
    a_not_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        out_valid |-> exp_count != 0)
        else begin
            errors++;
            $display("ERROR: %s: output piece with no expected piece pending", test_name);
        end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Ready one cycle in four, slower than the parser, so the queue fills up
    always @(posedge aclk) begin
        out_ready <= ready_rand ? (($random(seed) % 4) == 0) : 1'b1;
    end

    function automatic rdma_req_t make_cmd(opcode_t op, req_mode_t mode, len_t len,
                                           logic last);
        rdma_req_t c;
        c.opcode = op;
        c.mode   = mode;
        c.qpn    = qpn_t'($random(seed));
        c.ssn    = ssn_t'($random(seed));
        c.last   = last;
        c.lvaddr = vaddr_t'({$random(seed), $random(seed)});
        c.rvaddr = vaddr_t'({$random(seed), $random(seed)});
        c.len    = len;
        c.params = params_t'($random(seed));
        return c;
    endfunction

    function automatic rdma_req_t random_cmd();
        int   pick;
        len_t len;
        logic last;
        pick = $unsigned($random(seed)) % 8;
        len  = len_t'($unsigned($random(seed)) % 12000);
        last = ($random(seed) % 2) != 0;
        case (pick)
            0: return make_cmd(APP_READ, MODE_APP, len, last);
            1: return make_cmd(APP_WRITE, MODE_APP, len, last);
            2: return make_cmd(APP_SEND, MODE_APP, len, last);
            3: return make_cmd(RC_RDMA_READ_REQUEST, MODE_RAW, len, last);
            4: return make_cmd(RC_RDMA_WRITE_LAST, MODE_RAW, len, last);
            5: return make_cmd(RC_SEND_MIDDLE, MODE_RAW, len, last);
            6: return make_cmd(RC_RDMA_WRITE_ONLY, MODE_RAW, len, last);
            default: return make_cmd(5'h15, MODE_APP, len, last); // Unknown opcode
        endcase
    endfunction

    // Called on a rising edge, returns on the edge of the transfer
    task automatic send_cmd(rdma_req_t c);
        int n;
        n        = 0;
        in_valid <= 1'b1;
        in_req   <= c;
        @(negedge aclk);
        while (!in_ready && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!in_ready) begin
            errors++;
            $display("ERROR: %s: command not accepted within %0d cycles", test_name, n);
        end
        @(posedge aclk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge aclk);
        while (exp_count != 0 && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (exp_count != 0) begin
            errors++;
            $display("ERROR: %s: %0d pieces still missing after %0d cycles",
                     test_name, exp_count, n);
        end
        @(posedge aclk);
    endtask

    initial begin
        int i;
        seed       = 95141;
        errors     = 0;
        checks     = 0;
        aresetn    = 1'b0;
        in_valid   = 1'b0;
        in_req     = '0;
        out_ready  = 1'b0;
        ready_rand = 1'b0;
        test_name  = "reset";
        repeat (4) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);

        test_name = "write_split";
        send_cmd(make_cmd(APP_WRITE, MODE_APP, PMTU * 5 / 2, 1'b1));
        wait_drain();

        test_name = "single_mtu_and_send_split";
        send_cmd(make_cmd(APP_WRITE, MODE_APP, PMTU, 1'b1));
        send_cmd(make_cmd(APP_SEND, MODE_APP, 100, 1'b1));
        send_cmd(make_cmd(APP_SEND, MODE_APP, 3 * PMTU + 7, 1'b1));
        wait_drain();

        test_name = "read_split";
        send_cmd(make_cmd(APP_READ, MODE_APP, 9000, 1'b1));
        wait_drain();

        test_name = "raw_and_dropped";
        send_cmd(make_cmd(RC_RDMA_WRITE_MIDDLE, MODE_RAW, 512, 1'b1)); // Last removed
        send_cmd(make_cmd(RC_SEND_LAST, MODE_RAW, 64, 1'b1));
        send_cmd(make_cmd(RC_RDMA_READ_REQUEST, MODE_RAW, 5000, 1'b1));
        send_cmd(make_cmd(5'h10, MODE_APP, 256, 1'b1));
        wait_drain();

        test_name  = "random_backpressure";
        ready_rand = 1'b1;
        for (i = 0; i < 40; i++) begin
            send_cmd(random_cmd());
        end
        wait_drain();

        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d expected pieces never came out", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/rdma_config.svh ====
/*
 * RDMA request path configuration
 * Field widths, path MTU, read split size and default output queue depth
 */

`ifndef RDMA_CONFIG_SVH
`define RDMA_CONFIG_SVH

// Request field widths in bits
`define RDMA_OPCODE_BITS     5
`define RDMA_QPN_BITS        10
`define RDMA_SSN_BITS        24
`define RDMA_VADDR_BITS      48
`define RDMA_LEN_BITS        32
`define RDMA_PARAMS_BITS     16

// Split sizes in bytes
`define RDMA_PMTU_BYTES      1024     // Largest WRITE/SEND payload
`define RDMA_MAX_SINGLE_READ 4096     // Largest single READ REQUEST

`define RDMA_QUEUE_DEPTH     8        // Output queue entries

`endif

// ==== hw/rdma_opcode_pkg.sv ====
/*
 * RDMA opcode package
 * RC transport opcodes, application command opcodes and the request mode
 */

`default_nettype none

`include "rdma_config.svh"

package rdma_opcode_pkg;

    // RC opcodes, IB transport encoding
    typedef enum logic [`RDMA_OPCODE_BITS-1:0] {
        RC_SEND_FIRST         = 5'h00,
        RC_SEND_MIDDLE        = 5'h01,
        RC_SEND_LAST          = 5'h02,
        RC_SEND_ONLY          = 5'h04,
        RC_RDMA_WRITE_FIRST   = 5'h06,
        RC_RDMA_WRITE_MIDDLE  = 5'h07,
        RC_RDMA_WRITE_LAST    = 5'h08,
        RC_RDMA_WRITE_ONLY    = 5'h0a,
        RC_RDMA_READ_REQUEST  = 5'h0c
    } rc_opcode_t;

    // Application commands, top of the opcode space
    typedef enum logic [`RDMA_OPCODE_BITS-1:0] {
        APP_READ  = 5'h1d,
        APP_WRITE = 5'h1e,
        APP_SEND  = 5'h1f
    } app_opcode_t;

    typedef enum logic {
        MODE_APP = 1'b0, // Split by the parser
        MODE_RAW = 1'b1  // Already a packet request
    } req_mode_t;

endpackage

`default_nettype wire

// ==== hw/rdma_req_parser.sv ====
/*
 * RDMA request parser
 * Accepts application or raw commands and cuts them into RC packet requests,
 * at most one path MTU per WRITE/SEND packet and one max read per READ REQUEST.
 * Raw non-read commands pass through with the last flag filtered.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rdma_config.svh"

module rdma_req_parser
    import rdma_opcode_pkg::*;
    import rdma_req_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      in_valid,
    output logic      in_ready,
    input  rdma_req_t in_req,

    output logic      pkt_valid,
    input  logic      pkt_ready,
    output rdma_req_t pkt_req
);

    localparam len_t PMTU   = len_t'(`RDMA_PMTU_BYTES);
    localparam len_t MAX_RD = len_t'(`RDMA_MAX_SINGLE_READ);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_PARSE_READ, ST_SEND_READ,
        ST_PARSE_WRITE_INIT, ST_PARSE_WRITE, ST_SEND_WRITE,
        ST_PARSE_SEND_INIT, ST_PARSE_SEND, ST_SEND_SEND,
        ST_SEND_BASE
    } state_t;

    state_t    state_q, state_d;
    rdma_req_t cmd_q, cmd_d;  // Remaining part of the command
    rdma_req_t pkt_q, pkt_d;  // Piece on offer to the queue

    len_t      piece_lim;
    logic      piece_fits;

    // Raw packets keep last only where it closes a message
    function automatic logic last_kept(opcode_t op);
        return op inside {RC_RDMA_WRITE_LAST, RC_RDMA_WRITE_ONLY,
                          RC_SEND_LAST, RC_SEND_ONLY};
    endfunction

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge aclk) begin
        cmd_q <= cmd_d;
        pkt_q <= pkt_d;
    end

    //////////////////////////////
    // Piece sizing
    //////////////////////////////

    assign piece_lim  = (state_q == ST_PARSE_READ) ? MAX_RD : PMTU;
    assign piece_fits = (cmd_q.len <= piece_lim); // Final or only piece

    //////////////////////////////
    // FSM and datapath
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        cmd_d   = cmd_q;
        pkt_d   = pkt_q;

        case (state_q)
            ST_IDLE: begin
                if (in_valid) begin
                    cmd_d = in_req;
                    if (in_req.mode == MODE_RAW) begin
                        if (in_req.opcode == RC_RDMA_READ_REQUEST) begin
                            state_d = ST_PARSE_READ;
                        end else begin
                            pkt_d      = in_req; // Pass through as is
                            pkt_d.last = in_req.last && last_kept(in_req.opcode);
                            state_d    = ST_SEND_BASE;
                        end
                    end else begin
                        case (in_req.opcode)
                            APP_READ:  state_d = ST_PARSE_READ;
                            APP_WRITE: state_d = ST_PARSE_WRITE_INIT;
                            APP_SEND:  state_d = ST_PARSE_SEND_INIT;
                            default:   state_d = ST_IDLE; // Unknown, dropped
                        endcase
                    end
                end
            end

            ST_PARSE_READ, ST_PARSE_WRITE_INIT, ST_PARSE_WRITE,
            ST_PARSE_SEND_INIT, ST_PARSE_SEND: begin
                // Common part of every cut
                pkt_d      = cmd_q;
                pkt_d.len  = piece_fits ? cmd_q.len : piece_lim;
                pkt_d.last = piece_fits && cmd_q.last;

                cmd_d.lvaddr = cmd_q.lvaddr + vaddr_t'(piece_lim);
                cmd_d.rvaddr = cmd_q.rvaddr + vaddr_t'(piece_lim);
                cmd_d.len    = piece_fits ? '0 : cmd_q.len - piece_lim;

                case (state_q)
                    ST_PARSE_READ: begin
                        pkt_d.opcode = RC_RDMA_READ_REQUEST;
                        state_d      = ST_SEND_READ;
                    end
                    ST_PARSE_WRITE_INIT: begin
                        pkt_d.opcode = piece_fits ? RC_RDMA_WRITE_ONLY : RC_RDMA_WRITE_FIRST;
                        state_d      = ST_SEND_WRITE;
                    end
                    ST_PARSE_WRITE: begin
                        pkt_d.opcode = piece_fits ? RC_RDMA_WRITE_LAST : RC_RDMA_WRITE_MIDDLE;
                        state_d      = ST_SEND_WRITE;
                    end
                    ST_PARSE_SEND_INIT: begin
                        pkt_d.opcode = piece_fits ? RC_SEND_ONLY : RC_SEND_FIRST;
                        pkt_d.rvaddr = '0; // No remote address on SEND
                        state_d      = ST_SEND_SEND;
                    end
                    default: begin
                        pkt_d.opcode = piece_fits ? RC_SEND_LAST : RC_SEND_MIDDLE;
                        pkt_d.rvaddr = '0;
                        state_d      = ST_SEND_SEND;
                    end
                endcase
            end

            ST_SEND_READ: begin
                if (pkt_ready) begin
                    state_d = (cmd_q.len != '0) ? ST_PARSE_READ : ST_IDLE;
                end
            end

            ST_SEND_WRITE: begin
                if (pkt_ready) begin
                    state_d = (cmd_q.len != '0) ? ST_PARSE_WRITE : ST_IDLE;
                end
            end

            ST_SEND_SEND: begin
                if (pkt_ready) begin
                    state_d = (cmd_q.len != '0) ? ST_PARSE_SEND : ST_IDLE;
                end
            end

            ST_SEND_BASE: begin
                if (pkt_ready) begin
                    state_d = ST_IDLE;
                end
            end

            default: state_d = ST_IDLE;
        endcase
    end

    // Outputs
    assign in_ready  = (state_q == ST_IDLE);
    assign pkt_valid = state_q inside {ST_SEND_READ, ST_SEND_WRITE, ST_SEND_SEND, ST_SEND_BASE};
    assign pkt_req   = pkt_q;

    //////////////////////////////
    // Assertions
    //////////////////////////////

    // Offered piece holds until the queue takes it
    a_pkt_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt_req));

    // Split pieces never exceed their size limit
    a_piece_len: assert property (@(posedge aclk) disable iff (!aresetn)
        pkt_valid |->
            (state_q == ST_SEND_BASE) ||
            ((state_q == ST_SEND_READ) ? (pkt_req.len <= MAX_RD) : (pkt_req.len <= PMTU)));

endmodule

`default_nettype wire

// ==== hw/rdma_req_pkg.sv ====
/*
 * RDMA request format package
 * Field types and the packed request used for commands and packet requests
 */

`default_nettype none

`include "rdma_config.svh"

package rdma_req_pkg;
    import rdma_opcode_pkg::*;

    typedef logic [`RDMA_QPN_BITS-1:0]    qpn_t;
    typedef logic [`RDMA_SSN_BITS-1:0]    ssn_t;
    typedef logic [`RDMA_VADDR_BITS-1:0]  vaddr_t;
    typedef logic [`RDMA_LEN_BITS-1:0]    len_t;     // Bytes
    typedef logic [`RDMA_PARAMS_BITS-1:0] params_t;
    typedef logic [`RDMA_OPCODE_BITS-1:0] opcode_t;  // RC or APP opcode

    typedef struct packed {
        opcode_t   opcode;
        req_mode_t mode;
        qpn_t      qpn;
        ssn_t      ssn;
        logic      last;    // Final piece of the work request
        vaddr_t    lvaddr;
        vaddr_t    rvaddr;
        len_t      len;
        params_t   params;
    } rdma_req_t;

endpackage

`default_nettype wire

// ==== hw/rdma_req_queue.sv ====
/*
 * RDMA request queue
 * Synchronous circular FIFO of packed requests, valid/ready on both sides
 */

`timescale 1ns/1ps
`default_nettype none

`include "rdma_config.svh"

module rdma_req_queue
    import rdma_req_pkg::*;
#(
    parameter int DEPTH = `RDMA_QUEUE_DEPTH
) (
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      in_valid,
    output logic      in_ready,
    input  rdma_req_t in_req,

    output logic      out_valid,
    input  logic      out_ready,
    output rdma_req_t out_req
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    rdma_req_t mem [DEPTH];
    ptr_t      wr_ptr_q, rd_ptr_q;
    cnt_t      count_q;    // Occupied entries
    logic      wr_en, rd_en;

    assign in_ready  = (count_q != cnt_t'(DEPTH)); // Not full
    assign out_valid = (count_q != '0);            // Not empty
    assign out_req   = mem[rd_ptr_q];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= in_req;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + cnt_t'(wr_en) - cnt_t'(rd_en);
        end
    end

    // Full queue has the write pointer lapped onto the oldest entry
    a_full_ptrs: assert property (@(posedge aclk) disable iff (!aresetn)
        (count_q == cnt_t'(DEPTH)) |-> (wr_ptr_q == rd_ptr_q));

    // Empty queue has both pointers on the same slot
    a_empty_ptrs: assert property (@(posedge aclk) disable iff (!aresetn)
        (count_q == '0) |-> (wr_ptr_q == rd_ptr_q));

endmodule

`default_nettype wire

// ==== hw/rdma_req_top.sv ====
/*
 * RDMA request splitter top
 * Parser followed by the output queue toward the transmitter
 */

`timescale 1ns/1ps
`default_nettype none

module rdma_req_top
    import rdma_req_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      in_valid,
    output logic      in_ready,
    input  rdma_req_t in_req,

    output logic      out_valid,
    input  logic      out_ready,
    output rdma_req_t out_req
);

    // Parser to queue
    logic      pkt_valid;
    logic      pkt_ready;
    rdma_req_t pkt_req;

    rdma_req_parser parser_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .pkt_req   (pkt_req)
    );

    rdma_req_queue queue_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (pkt_valid),
        .in_ready  (pkt_ready),
        .in_req    (pkt_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_req   (out_req)
    );

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/rdma_opcode_pkg.sv
hw/rdma_req_pkg.sv
hw/rdma_req_parser.sv
hw/rdma_req_queue.sv
hw/rdma_req_top.sv
bench/tb_rdma_req_top.sv
